/* sim.f */
hw/mac_glue_pkg.sv
hw/reset_sequencer.sv
hw/bus_cycle_ctrl.sv
hw/floppy_loader.sv
hw/sdram_arbiter.sv
hw/mac_glue_top.sv
verif/mac_glue_chk.sv
verif/mac_glue_tb.sv

/* Makefile */
# Verilator build and run of the glue testbench
# override on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= mac_glue_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/mac_glue_tb.sv */
// reset_hold and act_hold shortened to 20 and 40; clk8_en_p is held high so every cycle is an enable
`timescale 1ns/1ps

module mac_glue_tb;

	import mac_glue_pkg::*;

	localparam int reset_hold = 20;
	localparam int act_hold   = 40;
	localparam int clk_period = 20;
	// longest single test in cycles as set by the slower of the two hold counters
	localparam int test_cycles = ((reset_hold > act_hold) ? reset_hold : act_hold) + 64;
	// image sizes in words for 800K and 400K disks
	localparam int ds_words = 409600;
	localparam int ss_words = 204800;

	// table operations
	localparam int op_reset  = 0;
	localparam int op_dl     = 1;
	localparam int op_detect = 2;
	localparam int op_eject  = 3;
	localparam int op_cpu    = 4;
	localparam int op_ack    = 5;
	localparam int op_led    = 6;

	logic clk_sys;
	logic reset;
	logic pll_locked, user_reset, cpu_reset_out_n;
	logic clk8_en_p, clk8_en_n, clk16_en_p, clk16_en_n;
	logic mem_4mb_sel, system_run, mem_4mb;
	logic [1:0] cpu_type_sel, cpu_type;
	logic cpu_reset_n, turbo, cpu_as_n, cpu_bus_control, select_ram, select_rom;
	logic [2:0] cpu_fc, cpu_addr_hi;
	logic cpu_dtack_n, cpu_vpa_n, cpu_en_p, cpu_en_n;
	logic ioctl_download, ioctl_wr, ioctl_wait, dio_bus_control, disk_act_in, led_user;
	logic [7:0] ioctl_index;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_data;
	logic [1:0] disk_eject, disk_motor, disk_inserted, disk_sides;
	logic [mem_addr_w-1:0] mem_addr;
	logic rom_oe_n, ram_oe_n, ram_we_n, mem_uds_n, mem_lds_n, disk_read_ack;
	logic [15:0] mem_data_out, sdram_out, sdram_din, mem_data_in;
	sdram_word_addr_u sdram_addr;
	logic [1:0] sdram_ds;
	logic sdram_we, sdram_oe;

	// ====================
	// test table
	// ====================
	string       test_name[$];
	int          test_op[$];
	logic [31:0] test_a[$];
	logic [31:0] test_b[$];
	logic [31:0] test_c[$];

	string      cur_name;
	int         test_err;
	int         pass_cnt;
	int         fail_cnt;
	int         seed;
	// expected drive state as the detect and eject rules leave it
	logic [1:0] model_ins;
	logic [1:0] model_sides;

	mac_glue_top #(.reset_hold(reset_hold), .act_hold(act_hold)) dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	task automatic add_test(input string name, input int op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] c);
		test_name.push_back(name);
		test_op.push_back(op);
		test_a.push_back(a);
		test_b.push_back(b);
		test_c.push_back(c);
	endtask

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else begin
			$display("FAILED %s %s: expected %h, actual %h", cur_name, what, exp, act);
			test_err++;
		end
	endtask

	task automatic require(input logic cond, input string msg);
		assert (cond === 1'b1)
		else begin
			$display("%s: %s", cur_name, msg);
			test_err++;
		end
	endtask

	// pulse user reset or drop pll lock, then count enables until the system runs
	task automatic reset_countdown(input logic [31:0] mem_sel, input logic [31:0] cpu_sel,
		input logic [31:0] src);
		int n;
		@(posedge clk_sys);
		if (src[0])
			pll_locked <= 1'b0;
		else
			user_reset <= 1'b1;
		mem_4mb_sel  <= mem_sel[0];
		cpu_type_sel <= cpu_sel[1:0];
		@(posedge clk_sys);
		user_reset <= 1'b0;
		pll_locked <= 1'b1;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
			@(negedge clk_sys);
		end while (!system_run && n < test_cycles);
		compare("enables until run", reset_hold + 1, n);
		compare("mem_4mb", mem_sel[0], mem_4mb);
		compare("cpu_type", cpu_sel[1:0], cpu_type);
		// new selections without a reset stay out
		@(posedge clk_sys);
		mem_4mb_sel  <= !mem_sel[0];
		cpu_type_sel <= ~cpu_sel[1:0];
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		compare("mem_4mb held", mem_sel[0], mem_4mb);
		compare("cpu_type held", cpu_sel[1:0], cpu_type);
	endtask

	// one word through the wait handshake and a single download slot
	task automatic download_slot(input logic [31:0] index, input logic [31:0] addr,
		input logic [31:0] data);
		int          n;
		int          delay;
		logic [24:0] exp_addr;
		logic [15:0] exp_din;
		exp_addr = {4'd1, index[1:0], addr[19:1]};
		exp_din  = {data[7:0], data[15:8]};
		delay    = 1 + ($unsigned($random(seed)) % 8);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= index[7:0];
		ioctl_addr     <= addr[24:0];
		ioctl_data     <= data[15:0];
		ioctl_wr       <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (!ioctl_wait && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		require(ioctl_wait, "ioctl_wait did not rise after ioctl_wr");
		repeat (delay) @(posedge clk_sys);
		@(negedge clk_sys);
		compare("ioctl_wait before slot", 1, ioctl_wait);
		@(posedge clk_sys);
		dio_bus_control <= 1'b1;
		@(negedge clk_sys);
		compare("sdram_we", 1, sdram_we);
		compare("sdram_ds", 2'b11, sdram_ds);
		compare("sdram_din", exp_din, sdram_din);
		compare("sdram_addr", exp_addr, sdram_addr);
		compare("region", 4'd1, sdram_addr.dl.region);
		compare("drive", index[1:0], sdram_addr.dl.drive);
		compare("mem_data_in", 16'hffff, mem_data_in);
		@(posedge clk_sys);
		dio_bus_control <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (ioctl_wait && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		require(!ioctl_wait, "ioctl_wait did not clear after the slot");
	endtask

	// end a download at a given word count
	task automatic image_detect(input logic [31:0] index, input logic [31:0] words);
		int drive;
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= index[7:0];
		ioctl_addr     <= {words[23:0], 1'b0};
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		if (index == 1 || index == 2) begin
			drive = index - 1;
			model_sides[drive] = (words == ds_words);
			model_ins[drive]   = (words == ds_words) || (words == ss_words);
		end
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		compare("disk_inserted", model_ins, disk_inserted);
		compare("disk_sides", model_sides, disk_sides);
	endtask

	task automatic eject_drive(input logic [31:0] mask);
		@(posedge clk_sys);
		disk_eject <= mask[1:0];
		@(posedge clk_sys);
		disk_eject <= 2'b00;
		model_ins   = model_ins & ~mask[1:0];
		model_sides = model_sides & ~mask[1:0];
		@(posedge clk_sys);
		@(negedge clk_sys);
		compare("disk_inserted", model_ins, disk_inserted);
		compare("disk_sides", model_sides, disk_sides);
	endtask

	// flags bit 0 rom, bit 1 disk read ack, bit 2 lds_n and bit 3 uds_n
	task automatic cpu_access(input logic [31:0] addr, input logic [31:0] flags,
		input logic [31:0] data);
		logic [24:0] exp_addr;
		logic [15:0] exp_data;
		logic [1:0]  exp_ds;
		logic [15:0] exp_din;
		exp_addr = {3'b000, flags[0], addr[21:1]};
		exp_ds   = ~flags[3:2];
		exp_din  = ~data[15:0];
		if (!flags[1])
			exp_data = data[15:0];
		else if (addr[0])
			exp_data = {data[7:0], data[7:0]};
		else
			exp_data = {data[15:8], data[15:8]};
		@(posedge clk_sys);
		mem_addr      <= addr[mem_addr_w-1:0];
		rom_oe_n      <= !flags[0];
		ram_oe_n      <= flags[0];
		disk_read_ack <= flags[1];
		mem_lds_n     <= flags[2];
		mem_uds_n     <= flags[3];
		sdram_out     <= data[15:0];
		mem_data_out  <= ~data[15:0];
		@(negedge clk_sys);
		compare("sdram_addr", exp_addr, sdram_addr);
		compare("rom flag", flags[0], sdram_addr.cpu.rom);
		compare("sdram_ds", exp_ds, sdram_ds);
		compare("sdram_oe", 1, sdram_oe);
		compare("sdram_we", 0, sdram_we);
		compare("sdram_din", exp_din, sdram_din);
		compare("mem_data_in", exp_data, mem_data_in);
		@(posedge clk_sys);
		rom_oe_n      <= 1'b1;
		ram_oe_n      <= 1'b1;
		disk_read_ack <= 1'b0;
	endtask

	// fc sits in bits 5:3 of code and a[23:21] in bits 2:0
	task automatic acknowledge_decode(input logic [31:0] code, input logic [31:0] fast);
		int         hold;
		logic [2:0] fc;
		logic [2:0] hi;
		fc   = code[5:3];
		hi   = code[2:0];
		hold = 1 + ($unsigned($random(seed)) % 4);
		@(posedge clk_sys);
		cpu_fc      <= fc;
		cpu_addr_hi <= hi;
		cpu_as_n    <= 1'b0;
		select_ram  <= 1'b1;
		turbo       <= fast[0];
		@(negedge clk_sys);
		compare("cpu_vpa_n", !(fc == 3'd7 || hi == 3'd7), cpu_vpa_n);
		compare("cpu_en_p", fast[0] ? clk16_en_p : clk8_en_p, cpu_en_p);
		compare("cpu_en_n", fast[0] ? clk16_en_n : clk8_en_n, cpu_en_n);
		if (!fast[0]) begin
			compare("cpu_dtack_n", hi == 3'd7, cpu_dtack_n);
		end else begin
			// dtack waits for the cpu slot
			repeat (hold) begin
				@(negedge clk_sys);
				compare("cpu_dtack_n before slot", 1, cpu_dtack_n);
			end
			@(posedge clk_sys);
			cpu_bus_control <= 1'b1;
			@(negedge clk_sys);
			compare("cpu_dtack_n at slot", 1, cpu_dtack_n);
			@(negedge clk_sys);
			compare("cpu_dtack_n after slot", 0, cpu_dtack_n);
		end
		@(posedge clk_sys);
		cpu_as_n        <= 1'b1;
		cpu_bus_control <= 1'b0;
		select_ram      <= 1'b0;
		turbo           <= 1'b0;
	endtask

	// led forced by a download and then held by one activity pulse
	task automatic led_hold(input logic [31:0] motor);
		int   n;
		int   k;
		logic idle;
		idle = |motor[1:0];
		@(posedge clk_sys);
		ioctl_index    <= 8'd0;
		ioctl_download <= 1'b1;
		disk_motor     <= motor[1:0];
		@(negedge clk_sys);
		compare("led during download", 1, led_user);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		compare("led idle", idle, led_user);
		@(posedge clk_sys);
		disk_act_in <= 1'b1;
		@(posedge clk_sys);
		disk_act_in <= 1'b0;
		n = 0;
		k = 0;
		while (k < test_cycles) begin
			@(negedge clk_sys);
			k++;
			if (led_user !== idle)
				n++;
			else if (n > 0)
				break;
		end
		require(k < test_cycles, "led_user did not return to idle");
		compare("led hold cycles", act_hold, n);
		@(posedge clk_sys);
		disk_motor <= 2'b00;
	endtask

	task automatic fill_table();
		add_test("reset_4mb_cpu2", op_reset, 1, 2, 0);
		add_test("reset_pll_1mb_cpu1", op_reset, 0, 1, 1);
		add_test("dl_word_drive0", op_dl, 1, 25'h0000246, 16'h1234);
		add_test("dl_word_drive1", op_dl, 2, 25'h00abcde, 16'hbeef);
		add_test("detect_ds_drive0", op_detect, 1, ds_words, 0);
		add_test("detect_ss_drive1", op_detect, 2, ss_words, 0);
		add_test("eject_drive0", op_eject, 1, 0, 0);
		add_test("detect_odd_size_drive1", op_detect, 2, 1000, 0);
		add_test("cpu_ram_word", op_cpu, 22'h012344, 32'h0, 16'hcafe);
		add_test("cpu_rom_upper", op_cpu, 22'h3f0102, 32'h5, 16'h8421);
		add_test("disk_byte_even", op_cpu, 22'h001000, 32'h2, 16'ha55a);
		add_test("disk_byte_odd", op_cpu, 22'h001001, 32'h2, 16'ha55a);
		add_test("ack_ram", op_ack, {26'd0, 3'd5, 3'd0}, 0, 0);
		add_test("ack_top_region", op_ack, {26'd0, 3'd5, 3'd7}, 0, 0);
		add_test("ack_int", op_ack, {26'd0, 3'd7, 3'd7}, 0, 0);
		add_test("ack_turbo", op_ack, {26'd0, 3'd5, 3'd2}, 1, 0);
		add_test("led_motor_off", op_led, 0, 0, 0);
		add_test("led_motor_on", op_led, 2, 0, 0);
	endtask

	// ====================
	// watchdog
	// ====================
	initial begin
		int limit;
		#1;
		limit = (test_name.size() * test_cycles + 100) * clk_period;
		#(limit);
		$display("timeout: run exceeded %0d ns, a test is stuck", limit);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		seed            = 32'h32c323c3;
		pass_cnt        = 0;
		fail_cnt        = 0;
		model_ins       = 2'b00;
		model_sides     = 2'b00;
		reset           = 1'b1;
		pll_locked      = 1'b0;
		user_reset      = 1'b0;
		cpu_reset_out_n = 1'b1;
		clk8_en_p       = 1'b1;
		clk8_en_n       = 1'b0;
		clk16_en_p      = 1'b0;
		clk16_en_n      = 1'b1;
		mem_4mb_sel     = 1'b0;
		cpu_type_sel    = 2'b00;
		cpu_reset_n     = 1'b1;
		turbo           = 1'b0;
		cpu_as_n        = 1'b1;
		cpu_fc          = 3'd0;
		cpu_addr_hi     = 3'd0;
		cpu_bus_control = 1'b0;
		select_ram      = 1'b0;
		select_rom      = 1'b0;
		ioctl_download  = 1'b0;
		ioctl_index     = 8'd0;
		ioctl_wr        = 1'b0;
		ioctl_addr      = '0;
		ioctl_data      = 16'h0000;
		dio_bus_control = 1'b0;
		disk_eject      = 2'b00;
		disk_act_in     = 1'b0;
		disk_motor      = 2'b00;
		mem_addr        = '0;
		rom_oe_n        = 1'b1;
		ram_oe_n        = 1'b1;
		ram_we_n        = 1'b1;
		mem_uds_n       = 1'b1;
		mem_lds_n       = 1'b1;
		mem_data_out    = 16'h0000;
		disk_read_ack   = 1'b0;
		sdram_out       = 16'h0000;
		fill_table();
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);
		pll_locked <= 1'b1;
		repeat (2) @(posedge clk_sys);
		for (int i = 0; i < test_name.size(); i++) begin
			cur_name = test_name[i];
			test_err = 0;
			case (test_op[i])
				op_reset:  reset_countdown(test_a[i], test_b[i], test_c[i]);
				op_dl:     download_slot(test_a[i], test_b[i], test_c[i]);
				op_detect: image_detect(test_a[i], test_b[i]);
				op_eject:  eject_drive(test_a[i]);
				op_cpu:    cpu_access(test_a[i], test_b[i], test_c[i]);
				op_ack:    acknowledge_decode(test_a[i], test_b[i]);
				default:   led_hold(test_a[i]);
			endcase
			if (test_err == 0) begin
				pass_cnt++;
				$display("PASS %s", cur_name);
			end else begin
				fail_cnt++;
				$display("FAIL %s (%0d errors)", cur_name, test_err);
			end
		end
		$display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* verif/mac_glue_chk.sv */
// bound into mac_glue_top; all properties sample on clk_sys and are idle while reset is high
`timescale 1ns/1ps

module mac_glue_chk (
	input logic clk_sys,
	input logic reset,
	input logic ioctl_wr,
	input logic ioctl_wait,
	input logic pll_locked,
	input logic clk8_en_p,
	input logic system_run,
	input logic sdram_we,
	input logic sdram_oe
);

	// ====================
	// handshake
	// ====================

	// a held word always comes from a host write one cycle before
	wait_after_wr: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(ioctl_wait) |-> $past(ioctl_wr))
		else $error("ioctl_wait rose without a preceding ioctl_wr");

	// ====================
	// reset and sdram
	// ====================

	// an unlocked pll stops the system on the next enable
	run_needs_pll: assert property (@(posedge clk_sys) disable iff (reset)
		(!pll_locked && clk8_en_p) |=> !system_run)
		else $error("system_run high while pll_locked is low");

	// read and write never requested together
	no_we_with_oe: assert property (@(posedge clk_sys) disable iff (reset)
		!(sdram_we && sdram_oe))
		else $error("sdram_we and sdram_oe high in the same cycle");

endmodule

bind mac_glue_top mac_glue_chk u_chk (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.ioctl_wr   (ioctl_wr),
	.ioctl_wait (ioctl_wait),
	.pll_locked (pll_locked),
	.clk8_en_p  (clk8_en_p),
	.system_run (system_run),
	.sdram_we   (sdram_we),
	.sdram_oe   (sdram_oe)
);

/* hw/mac_glue_top.sv */
// glue only; slot timing, clock enables and sdram device control come from outside
`timescale 1ns/1ps

module mac_glue_top #(
	parameter int reset_hold = 16'hffff,
	parameter int act_hold   = 500000
) (
	input  logic                                clk_sys,
	input  logic                                reset,
	// ==================== reset and clocking
	input  logic                                pll_locked,
	input  logic                                user_reset,
	input  logic                                cpu_reset_out_n,
	input  logic                                clk8_en_p,
	input  logic                                clk8_en_n,
	input  logic                                clk16_en_p,
	input  logic                                clk16_en_n,
	input  logic                                mem_4mb_sel,
	input  logic [1:0]                          cpu_type_sel,
	output logic                                system_run,
	output logic                                mem_4mb,
	output logic [1:0]                          cpu_type,
	// ==================== cpu bus cycle
	input  logic                                cpu_reset_n,
	input  logic                                turbo,
	input  logic                                cpu_as_n,
	input  logic [2:0]                          cpu_fc,
	input  logic [2:0]                          cpu_addr_hi,
	input  logic                                cpu_bus_control,
	input  logic                                select_ram,
	input  logic                                select_rom,
	output logic                                cpu_dtack_n,
	output logic                                cpu_vpa_n,
	output logic                                cpu_en_p,
	output logic                                cpu_en_n,
	// ==================== host download and floppy
	input  logic                                ioctl_download,
	input  logic [7:0]                          ioctl_index,
	input  logic                                ioctl_wr,
	input  logic [24:0]                         ioctl_addr,
	input  logic [15:0]                         ioctl_data,
	output logic                                ioctl_wait,
	input  logic                                dio_bus_control,
	input  logic [1:0]                          disk_eject,
	input  logic                                disk_act_in,
	input  logic [1:0]                          disk_motor,
	output logic [1:0]                          disk_inserted,
	output logic [1:0]                          disk_sides,
	output logic                                led_user,
	// ==================== chipset memory and sdram
	input  logic [mac_glue_pkg::mem_addr_w-1:0] mem_addr,
	input  logic                                rom_oe_n,
	input  logic                                ram_oe_n,
	input  logic                                ram_we_n,
	input  logic                                mem_uds_n,
	input  logic                                mem_lds_n,
	input  logic [15:0]                         mem_data_out,
	input  logic                                disk_read_ack,
	input  logic [15:0]                         sdram_out,
	output mac_glue_pkg::sdram_word_addr_u      sdram_addr,
	output logic [15:0]                         sdram_din,
	output logic [1:0]                          sdram_ds,
	output logic                                sdram_we,
	output logic                                sdram_oe,
	output logic [15:0]                         mem_data_in
);

	// held download word on its way to the sdram
	logic [20:0] dio_a;
	logic [15:0] dio_data;
	logic        dio_write;

	reset_sequencer #(.reset_hold(reset_hold)) u_reset_sequencer (.*);

	bus_cycle_ctrl u_bus_cycle_ctrl (.*);

	floppy_loader #(.act_hold(act_hold)) u_floppy_loader (.*);

	sdram_arbiter u_sdram_arbiter (.*);

endmodule

/* hw/sdram_arbiter.sv */
// purely combinational; the download owns the sdram only while dio_bus_control is high
`timescale 1ns/1ps

module sdram_arbiter (
	input  logic                              ioctl_download,
	input  logic                              dio_bus_control,
	input  logic                              dio_write,
	input  logic [20:0]                       dio_a,
	input  logic [15:0]                       dio_data,
	input  logic [mac_glue_pkg::mem_addr_w-1:0] mem_addr,
	input  logic                              rom_oe_n,
	input  logic                              ram_oe_n,
	input  logic                              ram_we_n,
	input  logic                              mem_uds_n,
	input  logic                              mem_lds_n,
	input  logic [15:0]                       mem_data_out,
	input  logic                              disk_read_ack,
	input  logic [15:0]                       sdram_out,
	output mac_glue_pkg::sdram_word_addr_u    sdram_addr,
	output logic [15:0]                       sdram_din,
	output logic [1:0]                        sdram_ds,
	output logic                              sdram_we,
	output logic                              sdram_oe,
	output logic [15:0]                       mem_data_in
);

	import mac_glue_pkg::*;

	logic        download_cycle;
	logic [15:0] disk_byte;

	assign download_cycle = ioctl_download && dio_bus_control;

	// ====================
	// request mux
	// ====================
	always_comb begin
		sdram_addr = '0;
		if (download_cycle) begin
			// full word write into the disk image region
			sdram_addr.dl.region = dl_region;
			sdram_addr.dl.drive  = dio_a[20:19];
			sdram_addr.dl.offset = dio_a[18:0];
			sdram_din = dio_data;
			sdram_ds  = 2'b11;
			sdram_we  = dio_write;
			sdram_oe  = 1'b0;
		end else begin
			// rom flag lifts rom reads above the ram
			sdram_addr.cpu.rom  = !rom_oe_n;
			sdram_addr.cpu.word = mem_addr[mem_addr_w-1:1];
			sdram_din = mem_data_out;
			sdram_ds  = {!mem_uds_n, !mem_lds_n};
			sdram_we  = !ram_we_n;
			sdram_oe  = !ram_oe_n || !rom_oe_n;
		end
	end

	// disk data is byte wide, mem_addr[0] picks the byte
	assign disk_byte = mem_addr[0] ? {sdram_out[7:0], sdram_out[7:0]}
		: {sdram_out[15:8], sdram_out[15:8]};

	// all ones while downloading keeps the screen black
	assign mem_data_in = download_cycle ? 16'hffff
		: disk_read_ack ? disk_byte : sdram_out;

endmodule

/* hw/floppy_loader.sv */
// host must hold ioctl_wr off while ioctl_wait is high; only indexes 1 and 2 are floppy drives
`timescale 1ns/1ps

module floppy_loader #(
	parameter int act_hold = 500000
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [15:0] ioctl_data,
	input  logic        dio_bus_control,
	input  logic [1:0]  disk_eject,
	input  logic        disk_act_in,
	input  logic [1:0]  disk_motor,
	output logic        ioctl_wait,
	output logic [20:0] dio_a,
	output logic [15:0] dio_data,
	output logic        dio_write,
	output logic [1:0]  disk_inserted,
	output logic [1:0]  disk_sides,
	output logic        led_user
);

	import mac_glue_pkg::*;

	localparam int act_w = $clog2(act_hold + 1);

	logic [dio_addr_w-1:0] dio_addr;
	logic                  dio_bus_control_d;
	logic                  download_d;
	logic                  download_end;
	logic [1:0]            dsk_ds;
	logic [1:0]            dsk_ss;
	logic [act_w-1:0]      act_cnt;
	logic                  disk_act;

	// host addresses bytes, the loader counts words
	assign dio_addr = ioctl_addr[24:1];

	assign download_end = download_d && !ioctl_download;

	// ====================
	// word capture
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_wait        <= 1'b0;
			dio_write         <= 1'b0;
			dio_bus_control_d <= 1'b0;
		end else begin
			dio_bus_control_d <= dio_bus_control;
			if (ioctl_wr)
				ioctl_wait <= 1'b1;
			// write request is frozen for the length of the slot
			if (!dio_bus_control)
				dio_write <= ioctl_wait;
			// slot closed with our word written
			if (dio_bus_control_d && !dio_bus_control && dio_write)
				ioctl_wait <= 1'b0;
		end
	end

	// 68k is big endian, host sends little endian words
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			dio_data <= {ioctl_data[7:0], ioctl_data[15:8]};
			dio_a    <= {ioctl_index[1:0], dio_addr[18:0]};
		end
	end

	// ====================
	// image detection
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d <= 1'b0;
			dsk_ds     <= 2'b00;
			dsk_ss     <= 2'b00;
		end else begin
			download_d <= ioctl_download;
			for (int i = 0; i < 2; i++) begin
				// final word count tells the image type
				if (download_end && (ioctl_index == 8'(i + 1))) begin
					dsk_ds[i] <= (dio_addr == dsk_ds_words);
					dsk_ss[i] <= (dio_addr == dsk_ss_words);
				end
				// eject from the os wins
				if (disk_eject[i]) begin
					dsk_ds[i] <= 1'b0;
					dsk_ss[i] <= 1'b0;
				end
			end
		end
	end

	// unknown sizes leave the drive empty
	assign disk_inserted = dsk_ds | dsk_ss;
	assign disk_sides    = dsk_ds;

	// activity led, retriggered by every access
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			act_cnt  <= '0;
			disk_act <= 1'b0;
		end else begin
			disk_act <= (act_cnt != '0);
			if (disk_act_in)
				act_cnt <= act_w'(act_hold);
			else if (act_cnt != '0)
				act_cnt <= act_cnt - 1'b1;
		end
	end

	// a spinning motor flips the led sense
	assign led_user = ioctl_download || (disk_act ^ |disk_motor);

endmodule

/* hw/bus_cycle_ctrl.sv */
// no wait-state count of its own; turbo acknowledge relies on cpu_bus_control from the slot timer
`timescale 1ns/1ps

module bus_cycle_ctrl (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       cpu_reset_n,
	input  logic       turbo,
	input  logic       cpu_as_n,
	input  logic       cpu_bus_control,
	input  logic       select_ram,
	input  logic       select_rom,
	input  logic [2:0] cpu_fc,
	input  logic [2:0] cpu_addr_hi,
	input  logic       clk8_en_p,
	input  logic       clk8_en_n,
	input  logic       clk16_en_p,
	input  logic       clk16_en_n,
	output logic       cpu_dtack_n,
	output logic       cpu_vpa_n,
	output logic       cpu_en_p,
	output logic       cpu_en_n
);

	import mac_glue_pkg::*;

	logic turbo_dtack_en;
	logic cpu_bus_control_d;
	logic bus_won;
	logic in_vpa_area;

	// cpu slot just started
	assign bus_won = cpu_bus_control && !cpu_bus_control_d;

	// ====================
	// turbo acknowledge
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset || !cpu_reset_n) begin
			turbo_dtack_en    <= 1'b0;
			cpu_bus_control_d <= 1'b0;
		end else begin
			cpu_bus_control_d <= cpu_bus_control;
			if (cpu_as_n) begin
				// strobe gone, bus cycle over
				turbo_dtack_en <= 1'b0;
			end else if (bus_won || (!select_rom && !select_ram)) begin
				// memory slot reached, or peripheral access with no slot to wait for
				turbo_dtack_en <= 1'b1;
			end
		end
	end

	// top 2MB is vpa space (via, scc, iwm and autovectors)
	assign in_vpa_area = !cpu_as_n && (cpu_addr_hi == vpa_region);

	// interrupt acknowledge always goes autovectored
	assign cpu_vpa_n = (cpu_fc == fc_int_ack) ? 1'b0 : !in_vpa_area;

	// dtack for everything outside vpa space, held off in turbo until enabled
	assign cpu_dtack_n = !(!cpu_as_n && (cpu_addr_hi != vpa_region))
		|| (turbo && !turbo_dtack_en);

	// cpu phase enables, 16 MHz in turbo
	assign cpu_en_p = turbo ? clk16_en_p : clk8_en_p;
	assign cpu_en_n = turbo ? clk16_en_n : clk8_en_n;

endmodule

/* hw/reset_sequencer.sv */
// steps only on clk8_en_p; memory and cpu selections apply only through a full reset countdown
`timescale 1ns/1ps

module reset_sequencer #(
	parameter int reset_hold = 16'hffff
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       clk8_en_p,
	input  logic       pll_locked,
	input  logic       user_reset,
	input  logic       cpu_reset_out_n,
	input  logic       mem_4mb_sel,
	input  logic [1:0] cpu_type_sel,
	output logic       system_run,
	output logic       mem_4mb,
	output logic [1:0] cpu_type
);

	logic [15:0] hold_cnt;
	logic        src_active;
	logic        latch_cfg;

	// pll still settling, user button / status reset, or cpu executed RESET
	assign src_active = !pll_locked || user_reset || !cpu_reset_out_n;

	// selections sampled for the whole countdown
	assign latch_cfg = clk8_en_p && !src_active && (hold_cnt != 16'd0);

	// ====================
	// countdown
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hold_cnt   <= 16'(reset_hold);
			system_run <= 1'b0;
		end else if (clk8_en_p) begin
			if (src_active) begin
				// any source restarts the full hold
				hold_cnt   <= 16'(reset_hold);
				system_run <= 1'b0;
			end else if (hold_cnt != 16'd0) begin
				hold_cnt <= hold_cnt - 16'd1;
			end else begin
				// count ran out, release on this enable
				system_run <= 1'b1;
			end
		end
	end

	// configuration latch
	always_ff @(posedge clk_sys) begin
		if (latch_cfg) begin
			mem_4mb  <= mem_4mb_sel;
			cpu_type <= cpu_type_sel;
		end
	end

endmodule

/* hw/mac_glue_pkg.sv */
// shared sizes and the sdram word address layout; image sizes assume 400K/800K raw DSK files

package mac_glue_pkg;

	// ====================
	// address widths
	// ====================

	// download word address, byte address from the host shifted right by one
	localparam int dio_addr_w = 24;

	// chipset byte address, 4MB ram space
	localparam int mem_addr_w = 22;

	// sdram word address, 32M words
	localparam int sdram_addr_w = 25;

	// ====================
	// floppy image sizes
	// ====================

	// sizes counted in 16 bit words, not bytes
	// 819200 byte double sided image
	localparam logic [dio_addr_w-1:0] dsk_ds_words = 24'd409600;
	// 409600 byte single sided image
	localparam logic [dio_addr_w-1:0] dsk_ss_words = 24'd204800;

	// ====================
	// bus decode constants
	// ====================

	// disk images sit above the os rom, region 1 of the sdram
	localparam logic [3:0] dl_region = 4'd1;

	// a[23:21] of the autovector and peripheral area
	localparam logic [2:0] vpa_region = 3'd7;

	// fc2..fc0 all set on interrupt acknowledge
	localparam logic [2:0] fc_int_ack = 3'd7;

	// download view of the sdram word address
	// drive index picks word offset 0x80000 or 0x100000
	typedef struct packed {
		logic [3:0]              region;
		logic [1:0]              drive;
		logic [sdram_addr_w-7:0] offset;
	} sdram_dl_view_t;

	// cpu/chipset view, rom flag moves rom above the ram words
	typedef struct packed {
		logic [2:0]              zero;
		logic                    rom;
		logic [sdram_addr_w-5:0] word;
	} sdram_cpu_view_t;

	// the same 25 address lines, decoded per bus owner
	typedef union packed {
		sdram_dl_view_t  dl;
		sdram_cpu_view_t cpu;
	} sdram_word_addr_u;

endpackage
